// File: dcache.f
common/dcache_addr_pkg.sv
common/dcache_bus_pkg.sv
dcache/dcache_ctrl.sv
dcache/dcache_way.sv
dcache/dcache_way_select.sv
src/dcache_top.sv
verif/l2_mem_model.sv
verif/tb_dcache.sv

// File: verif/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache
    import dcache_addr_pkg::*, dcache_bus_pkg::*;
;

    localparam int CLK_PERIOD     = 20;
    localparam int NUM_RANDOM     = 2000;
    localparam int NUM_OPS        = NUM_RANDOM + 40;    // directed ops stay well below 40
    localparam int TIMEOUT_CYCLES = NUM_OPS * 40 + 16;

    logic        clk;
    logic        rst_n;
    logic        load_req;
    paddr_t      load_addr;
    logic        load_ack;
    word_t       load_data;
    logic        store_req;
    store_cmd_t  store;
    logic        store_ack;
    l2_req_t     l2;
    logic        l2_ack;
    line_t       l2_rdata;
    logic        wb_valid;
    logic [31:0] wb_addr;
    line_t       wb_line;

    word_t       ref_mem [logic [29:0]];   // flat word model
    word_t       exp_load;
    string       cur_test;
    int          l2_reads;
    int          l2_writes;
    int          req_cycles;
    logic [31:0] last_read_addr;

    dcache_top #(.NUM_WAYS(2)) u_dcache_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_req  (load_req),
        .load_addr (load_addr),
        .load_ack  (load_ack),
        .load_data (load_data),
        .store_req (store_req),
        .store     (store),
        .store_ack (store_ack),
        .l2        (l2),
        .l2_ack    (l2_ack),
        .l2_rdata  (l2_rdata)
    );

    l2_mem_model u_l2 (
        .clk      (clk),
        .rst_n    (rst_n),
        .l2       (l2),
        .l2_ack   (l2_ack),
        .l2_rdata (l2_rdata),
        .wb_valid (wb_valid),
        .wb_addr  (wb_addr),
        .wb_line  (wb_line)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // initial L2 contents, a fixed function of the word address
    function automatic word_t l2_init_word(input logic [31:0] addr);
        return ({addr[31:2], 2'b00} * 32'h9e37_79b9) ^ 32'h5c3a_17e1;
    endfunction

    function automatic word_t expected_word(input logic [31:0] addr);
        if (ref_mem.exists(addr[31:2]))
            return ref_mem[addr[31:2]];
        return l2_init_word(addr);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // drives one request until its ack and returns the accept to ack latency
    task automatic do_op(input bit is_store, input logic [31:0] addr, input word_t data,
                         output int latency);
        int cycles;
        cycles = 0;
        if (is_store) begin
            ref_mem[addr[31:2]] = data;
            store.addr = addr;
            store.data = data;
            store_req  = 1'b1;
        end else begin
            exp_load  = expected_word(addr);
            load_addr = addr;
            load_req  = 1'b1;
        end
        do begin
            @(posedge clk);
            cycles++;
        end while (!(load_ack || store_ack));
        check_value({cur_test, " ack kind"}, 32'(is_store), 32'(store_ack));
        #2;
        load_req  = 1'b0;
        store_req = 1'b0;
        latency   = cycles - 1;
    endtask

    // L2 traffic monitor
    always @(posedge clk) begin
        if (l2.req)
            req_cycles++;
        if (l2.req && l2_ack) begin
            if (l2.write) begin
                l2_writes++;
            end else begin
                l2_reads++;
                last_read_addr = l2.addr;
            end
        end
    end

    // compare load results and write-back lines against the reference
    always @(posedge clk) begin
        if (load_ack)
            check_value(cur_test, exp_load, load_data);
        if (wb_valid) begin
            for (int w = 0; w < WORDS_PER_LINE; w++)
                check_value({cur_test, " writeback"},
                            expected_word({wb_addr[31:6], 4'(w), 2'b00}),
                            wb_line[w*WORD_BITS +: WORD_BITS]);
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Watchdog expired, the cache stopped answering requests");
        $display("Simulation failed");
        $fatal(1);
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] r;
        word_t       data;
        int          lat;
        int          reads0;
        int          writes0;
        int          req0;

        void'($urandom(32'h4874_1b78));
        rst_n      = 1'b0;
        load_req   = 1'b0;
        load_addr  = '0;
        store_req  = 1'b0;
        store      = '0;
        exp_load   = '0;
        l2_reads   = 0;
        l2_writes  = 0;
        req_cycles = 0;
        cur_test   = "reset";
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (4) begin
            @(posedge clk);
            check_value("reset idle", 32'd0, {29'd0, load_ack, store_ack, l2.req});
        end
        #2;

        cur_test = "cold load";
        addr     = {20'h0_0a00, 6'd5, 4'd7, 2'b00};
        reads0   = l2_reads;
        do_op(1'b0, addr, '0, lat);
        check_value("cold load reads", reads0 + 1, l2_reads);
        check_value("cold load line addr", {addr[31:6], 6'd0}, last_read_addr);

        cur_test = "hit load";
        req0     = req_cycles;
        do_op(1'b0, {20'h0_0a00, 6'd5, 4'd2, 2'b00}, '0, lat);
        check_value("hit load l2 req", req0, req_cycles);
        check_value("hit load latency", 32'd2, lat);

        cur_test = "store neighbors";
        do_op(1'b1, {20'h0_0a00, 6'd5, 4'd8, 2'b00}, 32'hdead_beef, lat);
        for (int w = 7; w <= 9; w++)
            do_op(1'b0, {20'h0_0a00, 6'd5, 4'(w), 2'b00}, '0, lat);

        cur_test = "dirty evict";
        writes0  = l2_writes;
        for (int t = 1; t <= 4; t++)
            do_op(1'b1, {20'h0_2000 + 20'(t), 6'd33, 4'd3, 2'b00}, 32'h5500_0000 + t, lat);
        // two ways both dirty, so the third and fourth store each evict one line
        check_value("dirty evict writes", writes0 + 2, l2_writes);
        for (int t = 1; t <= 4; t++)
            do_op(1'b0, {20'h0_2000 + 20'(t), 6'd33, 4'd3, 2'b00}, '0, lat);

        cur_test = "random";
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r    = $urandom;
            data = $urandom;
            addr = {20'h3_0000 + 20'(r[2:0]) * 20'h0_0101, r[4:3], 4'b0101, r[8:5], 2'b00};
            do_op(r[9], addr, data, lat);
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/l2_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module l2_mem_model
    import dcache_addr_pkg::*, dcache_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  l2_req_t     l2,
    output logic        l2_ack,
    output line_t       l2_rdata,
    output logic        wb_valid,   // write-back hook, one pulse per L2 write
    output logic [31:0] wb_addr,
    output line_t       wb_line
);

    line_t mem [logic [25:0]];      // sparse, keyed by line address
    logic  busy;
    int    wait_cnt;

    function automatic word_t init_word(input logic [31:0] addr);
        return ({addr[31:2], 2'b00} * 32'h9e37_79b9) ^ 32'h5c3a_17e1;
    endfunction

    function automatic line_t read_line(input logic [31:0] addr);
        line_t line;
        if (mem.exists(addr[31:6]))
            return mem[addr[31:6]];
        for (int w = 0; w < WORDS_PER_LINE; w++)
            line[w*WORD_BITS +: WORD_BITS] = init_word({addr[31:6], 4'(w), 2'b00});
        return line;
    endfunction

    initial begin
        l2_ack   = 1'b0;
        l2_rdata = '0;
        wb_valid = 1'b0;
        wb_addr  = '0;
        wb_line  = '0;
        busy     = 1'b0;
        wait_cnt = 0;
    end

    always @(posedge clk) begin
        l2_ack   <= #2 1'b0;
        wb_valid <= #2 1'b0;
        if (!rst_n) begin
            busy = 1'b0;
        end else if (l2_ack) begin
            busy = 1'b0;    // fields still show the finished transfer
        end else if (busy) begin
            if (wait_cnt == 0) begin
                busy = 1'b0;
                l2_ack <= #2 1'b1;
                if (l2.write) begin
                    mem[l2.addr[31:6]] = l2.wdata;
                    wb_valid <= #2 1'b1;
                    wb_addr  <= #2 l2.addr;
                    wb_line  <= #2 l2.wdata;
                end else begin
                    l2_rdata <= #2 read_line(l2.addr);
                end
            end else begin
                wait_cnt = wait_cnt - 1;
            end
        end else if (l2.req) begin
            busy     = 1'b1;
            wait_cnt = $urandom % 8;   // ack after 1..8 cycles
        end
    end

endmodule

`default_nettype wire

// File: src/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top
    import dcache_addr_pkg::*, dcache_bus_pkg::*;
#(
    parameter int NUM_WAYS = 2
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       load_req,
    input  paddr_t     load_addr,
    output logic       load_ack,
    output word_t      load_data,
    input  logic       store_req,
    input  store_cmd_t store,
    output logic       store_ack,
    output l2_req_t    l2,
    input  logic       l2_ack,
    input  line_t      l2_rdata
);

    way_cmd_t                    way_cmd;
    logic [NUM_WAYS-1:0]         way_wr;
    way_status_t                 way_status [NUM_WAYS];
    lookup_t                     lookup;
    logic [$clog2(NUM_WAYS)-1:0] victim_ptr;

    if (NUM_WAYS > MAX_WAYS || NUM_WAYS < 2) begin : g_bad_ways
        $error("NUM_WAYS out of range");
    end

    dcache_ctrl #(.NUM_WAYS(NUM_WAYS)) u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_req   (load_req),
        .load_addr  (load_addr),
        .store_req  (store_req),
        .store      (store),
        .load_ack   (load_ack),
        .load_data  (load_data),
        .store_ack  (store_ack),
        .l2         (l2),
        .l2_ack     (l2_ack),
        .l2_rdata   (l2_rdata),
        .way_cmd    (way_cmd),
        .way_wr     (way_wr),
        .victim_ptr (victim_ptr),
        .lookup     (lookup)
    );

    for (genvar i = 0; i < NUM_WAYS; i++) begin : g_way
        dcache_way u_way (
            .clk    (clk),
            .rst_n  (rst_n),
            .cmd    (way_cmd),
            .wr     (way_wr[i]),
            .status (way_status[i])
        );
    end

    dcache_way_select #(.NUM_WAYS(NUM_WAYS)) u_way_select (
        .status     (way_status),
        .victim_ptr (victim_ptr),
        .word_sel   (way_cmd.word_sel),
        .lookup     (lookup)
    );

endmodule

`default_nettype wire

// File: dcache/dcache_way_select.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_way_select
    import dcache_addr_pkg::*, dcache_bus_pkg::*;
#(
    parameter int NUM_WAYS = 2
) (
    input  way_status_t                 status [NUM_WAYS],
    input  logic [$clog2(NUM_WAYS)-1:0] victim_ptr,
    input  word_sel_t                   word_sel,
    output lookup_t                     lookup
);

    logic [NUM_WAYS-1:0] hit_vec;
    logic [NUM_WAYS-1:0] victim_vec;
    line_t               hit_line;

    always_comb begin
        hit_vec    = '0;
        hit_line   = '0;
        victim_vec = '0;
        victim_vec[victim_ptr] = 1'b1;      // all valid, round robin
        // walk downwards so the lowest invalid way wins
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            hit_vec[w] = status[w].hit;
            if (status[w].hit)
                hit_line = hit_line | status[w].line;
            if (!status[w].valid) begin
                victim_vec    = '0;
                victim_vec[w] = 1'b1;
            end
        end
    end

    always_comb begin
        lookup                       = '0;
        lookup.any_hit               = |hit_vec;
        lookup.hit_way[NUM_WAYS-1:0] = hit_vec;
        lookup.victim_way[NUM_WAYS-1:0] = victim_vec;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (victim_vec[w]) begin
                lookup.victim_dirty = status[w].valid && status[w].dirty;
                lookup.victim_tag   = status[w].tag;
                lookup.victim_line  = status[w].line;
            end
        end
        lookup.hit_word = hit_line[word_sel*WORD_BITS +: WORD_BITS];
    end

    a_hit_onehot: assert final ($onehot0(hit_vec));

endmodule

`default_nettype wire

// File: dcache/dcache_way.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_way
    import dcache_addr_pkg::*, dcache_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  way_cmd_t    cmd,
    input  logic        wr,
    output way_status_t status
);

    logic [NUM_SETS-1:0] valid_mem;
    logic [NUM_SETS-1:0] dirty_mem;
    tag_t                tag_mem  [NUM_SETS];
    line_t               line_mem [NUM_SETS];

    logic  valid_q;
    logic  dirty_q;
    tag_t  tag_q;
    line_t line_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            valid_mem <= '0;
        else if (wr && cmd.fill_line)
            valid_mem[cmd.index] <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            if (cmd.fill_line) begin
                tag_mem[cmd.index]  <= cmd.tag;
                line_mem[cmd.index] <= cmd.wline;
            end else if (cmd.wr_word) begin
                line_mem[cmd.index][cmd.word_sel*WORD_BITS +: WORD_BITS] <= cmd.wword;
            end
            if (cmd.set_dirty)
                dirty_mem[cmd.index] <= 1'b1;
            else if (cmd.clr_dirty)
                dirty_mem[cmd.index] <= 1'b0;
        end
    end

    // set read, held until the next rd_en
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            dirty_q <= 1'b0;
        end else if (cmd.rd_en) begin
            valid_q <= valid_mem[cmd.index];
            dirty_q <= dirty_mem[cmd.index];
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.rd_en) begin
            tag_q  <= tag_mem[cmd.index];
            line_q <= line_mem[cmd.index];
        end
    end

    always_comb begin
        status.valid = valid_q;
        status.dirty = dirty_q;
        status.tag   = tag_q;
        status.line  = line_q;
        status.hit   = valid_q && (tag_q == cmd.tag);    // cmd.tag is the latched request
    end

    a_one_write: assert property (@(posedge clk) disable iff (!rst_n)
        wr |-> !(cmd.fill_line && cmd.wr_word));

endmodule

`default_nettype wire

// File: dcache/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl
    import dcache_addr_pkg::*, dcache_bus_pkg::*;
#(
    parameter int NUM_WAYS = 2
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        load_req,
    input  paddr_t                      load_addr,
    input  logic                        store_req,
    input  store_cmd_t                  store,
    output logic                        load_ack,
    output word_t                       load_data,
    output logic                        store_ack,
    output l2_req_t                     l2,
    input  logic                        l2_ack,
    input  line_t                       l2_rdata,
    output way_cmd_t                    way_cmd,
    output logic [NUM_WAYS-1:0]         way_wr,
    output logic [$clog2(NUM_WAYS)-1:0] victim_ptr,
    input  lookup_t                     lookup
);

    ctrl_state_e state, next_state;
    paddr_t      in_addr;
    paddr_t      req_addr;
    word_t       req_data;
    logic        req_store;
    logic        accept;
    logic        done;
    line_t       fill_data;

    assign in_addr = store_req ? store.addr : load_addr;     // store wins
    assign accept  = (state == ST_IDLE) && !(load_ack || store_ack) && (load_req || store_req);
    assign done    = ((state == ST_LOOKUP) && lookup.any_hit) || ((state == ST_REFILL) && l2_ack);

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE:      if (accept) next_state = ST_LOOKUP;
            ST_LOOKUP: begin
                if (lookup.any_hit)
                    next_state = ST_IDLE;
                else if (lookup.victim_dirty)
                    next_state = ST_WRITEBACK;
                else
                    next_state = ST_REFILL;
            end
            ST_WRITEBACK: if (l2_ack) next_state = ST_REFILL;
            ST_REFILL:    if (l2_ack) next_state = ST_IDLE;
            default:      next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            req_store  <= 1'b0;
            victim_ptr <= '0;
            load_ack   <= 1'b0;
            store_ack  <= 1'b0;
        end else begin
            state     <= next_state;
            load_ack  <= done && !req_store;
            store_ack <= done && req_store;
            if (accept)
                req_store <= store_req;
            if ((state == ST_REFILL) && l2_ack)
                victim_ptr <= victim_ptr + 1'b1;    // round robin step per miss
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= in_addr;
            req_data <= store.data;
        end
        if (done && !req_store) begin
            if (state == ST_LOOKUP)
                load_data <= lookup.hit_word;
            else
                load_data <= l2_rdata[req_addr.word*WORD_BITS +: WORD_BITS];
        end
    end

    // store miss merges its word into the refill
    always_comb begin
        fill_data = l2_rdata;
        if (req_store)
            fill_data[req_addr.word*WORD_BITS +: WORD_BITS] = req_data;
    end

    always_comb begin
        way_cmd          = '0;
        way_cmd.rd_en    = accept;
        way_cmd.index    = (state == ST_IDLE) ? in_addr.index : req_addr.index;
        way_cmd.tag      = req_addr.tag;
        way_cmd.word_sel = req_addr.word;
        way_cmd.wword    = req_data;
        way_cmd.wline    = fill_data;
        way_wr           = '0;
        if ((state == ST_LOOKUP) && lookup.any_hit && req_store) begin
            way_cmd.wr_word   = 1'b1;
            way_cmd.set_dirty = 1'b1;
            way_wr            = lookup.hit_way[NUM_WAYS-1:0];
        end else if ((state == ST_REFILL) && l2_ack) begin
            way_cmd.fill_line = 1'b1;
            way_cmd.set_dirty = req_store;
            way_cmd.clr_dirty = !req_store;
            way_wr            = lookup.victim_way[NUM_WAYS-1:0];
        end
    end

    always_comb begin
        l2.req   = (state == ST_WRITEBACK) || (state == ST_REFILL);
        l2.write = (state == ST_WRITEBACK);
        if (l2.write)
            l2.addr = {lookup.victim_tag, req_addr.index, {(OFFSET_BITS+2){1'b0}}};
        else
            l2.addr = {req_addr.tag, req_addr.index, {(OFFSET_BITS+2){1'b0}}};
        l2.wdata = lookup.victim_line;
    end

    a_l2_hold: assert property (@(posedge clk) disable iff (!rst_n)
        l2.req && !l2_ack |=> l2.req && $stable(l2));

    // never more than one way written in a cycle
    a_wr_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(way_wr));

    // acks only right after a return to idle
    a_ack_when: assert property (@(posedge clk) disable iff (!rst_n)
        (load_ack || store_ack) |-> (state == ST_IDLE) &&
            ($past(state) inside {ST_LOOKUP, ST_REFILL}));

endmodule

`default_nettype wire

// File: common/dcache_bus_pkg.sv
`default_nettype none

package dcache_bus_pkg;

    import dcache_addr_pkg::*;

    // width of the way vectors carried in lookup_t, NUM_WAYS must not exceed it
    localparam int MAX_WAYS = 8;

    typedef logic [MAX_WAYS-1:0] way_vec_t;

    typedef struct packed {
        paddr_t addr;
        word_t  data;
    } store_cmd_t;

    typedef struct packed {
        logic      rd_en;       // latch the set into the status regs
        index_t    index;
        tag_t      tag;
        logic      fill_line;   // whole line write, sets valid
        line_t     wline;
        logic      wr_word;
        word_sel_t word_sel;
        word_t     wword;
        logic      set_dirty;
        logic      clr_dirty;
    } way_cmd_t;

    typedef struct packed {
        logic  valid;
        logic  dirty;
        tag_t  tag;
        line_t line;
        logic  hit;
    } way_status_t;

    typedef struct packed {
        logic     any_hit;
        way_vec_t hit_way;      // one-hot
        way_vec_t victim_way;   // one-hot
        logic     victim_dirty;
        tag_t     victim_tag;
        line_t    victim_line;
        word_t    hit_word;
    } lookup_t;

    typedef struct packed {
        logic        req;
        logic        write;
        logic [31:0] addr;      // line aligned
        line_t       wdata;
    } l2_req_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_REFILL
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: common/dcache_addr_pkg.sv
`default_nettype none

package dcache_addr_pkg;

    localparam int WORD_BITS      = 32;
    localparam int WORDS_PER_LINE = 16;
    localparam int LINE_BITS      = WORD_BITS * WORDS_PER_LINE;   // 512
    localparam int NUM_SETS       = 64;

    localparam int INDEX_BITS  = 6;
    localparam int OFFSET_BITS = 4;     // word select within a line
    localparam int TAG_BITS    = 20;

    typedef logic [WORD_BITS-1:0]   word_t;
    typedef logic [LINE_BITS-1:0]   line_t;     // word 0 in the low bits
    typedef logic [TAG_BITS-1:0]    tag_t;
    typedef logic [INDEX_BITS-1:0]  index_t;
    typedef logic [OFFSET_BITS-1:0] word_sel_t;

    typedef struct packed {
        tag_t       tag;        // 31..12
        index_t     index;      // 11..6
        word_sel_t  word;       // 5..2
        logic [1:0] byte_off;   // ignored, stores are full words
    } paddr_t;

endpackage

`default_nettype wire
